// File: design/game_pkg.sv
// Shared sizes, timing constants, start picture, MAX7219 codes and FSM states for the game core
`default_nettype none

package game_pkg;

	// ========================================================================
	// Matrix geometry
	// ========================================================================
	localparam int ROWS  = 8;
	localparam int COLS  = 8;
	localparam int ROW_W = 3;
	localparam int COL_W = 3;

	// Bit i of a row lights column i
	typedef logic [COLS-1:0]  row_t;
	typedef logic [ROW_W-1:0] row_addr_t;
	typedef logic [COL_W-1:0] col_t;

	// ========================================================================
	// Game constants
	// ========================================================================
	localparam int DEBOUNCE_CYCLES = 8;

	localparam row_addr_t PLAYER_ROW       = 3'd0;
	localparam col_t      PLAYER_START_COL = 3'd3;

	// Start picture, element 0 is row 0
	localparam row_t START_SCREEN [ROWS] = '{
		8'h00,
		8'h66,
		8'h22,
		8'h22,
		8'h44,
		8'h44,
		8'h66,
		8'h00
	};

	// ========================================================================
	// MAX7219 serial link
	// ========================================================================
	localparam int SCLK_HALF   = 2;
	localparam int FRAME_BITS  = 16;
	// Shutdown, test, decode, scan limit, intensity, wake up
	localparam int SETUP_WORDS = 6;

	localparam logic [7:0] INTENSITY = 8'h0A;

	localparam logic [7:0] REG_DIGIT0     = 8'h01;
	localparam logic [7:0] REG_DECODE     = 8'h09;
	localparam logic [7:0] REG_INTENSITY  = 8'h0A;
	localparam logic [7:0] REG_SCAN_LIMIT = 8'h0B;
	localparam logic [7:0] REG_SHUTDOWN   = 8'h0C;
	localparam logic [7:0] REG_TEST       = 8'h0F;

	// ========================================================================
	// State machines
	// ========================================================================
	typedef enum logic [1:0] {
		LOAD_START,
		WAIT_START,
		CLEAR_FIELD,
		PLAY
	} ctrl_state_t;

	typedef enum logic [1:0] {
		SETUP,
		REFRESH,
		SHIFT,
		GAP
	} drv_state_t;

endpackage

`default_nettype wire

// File: design/button_debounce.sv
// Turns one raw active-low push button into a single-cycle press pulse after a stable low
`timescale 1ns/1ps
`default_nettype none

module button_debounce (
	input  wire  clock_50,
	input  wire  rst,
	input  wire  button_n,
	output logic press
);

	logic sync_q1;
	logic sync_q2;
	// Saturates at DEBOUNCE_CYCLES until the button is released
	logic [$clog2(game_pkg::DEBOUNCE_CYCLES + 1)-1:0] low_cnt;

	always_ff @(posedge clock_50) begin
		if (rst) begin
			sync_q1 <= 1'b1;
			sync_q2 <= 1'b1;
			low_cnt <= '0;
			press   <= 1'b0;
		end else begin
			// Two-flop synchronizer, idle high
			sync_q1 <= button_n;
			sync_q2 <= sync_q1;
			press   <= 1'b0;
			if (sync_q2) begin
				low_cnt <= '0;
			end else if (low_cnt != $bits(low_cnt)'(game_pkg::DEBOUNCE_CYCLES)) begin
				low_cnt <= low_cnt + 1'b1;
				// Fires on the last counting step only
				press   <= (low_cnt == $bits(low_cnt)'(game_pkg::DEBOUNCE_CYCLES - 1));
			end
		end
	end

	// One pulse per press, never a level
	a_single_pulse: assert property (@(posedge clock_50) disable iff (rst)
		press |=> !press);

endmodule

`default_nettype wire

// File: design/game_control.sv
// Top game FSM that streams the start picture or an empty field into the frame store
`timescale 1ns/1ps
`default_nettype none

module game_control (
	input  wire                  clock_50,
	input  wire                  rst,
	input  wire                  start_press,
	output logic                 playing,
	output logic                 ctrl_we,
	output game_pkg::row_addr_t  ctrl_addr,
	output game_pkg::row_t       ctrl_data
);

	game_pkg::ctrl_state_t state;
	game_pkg::row_addr_t   row_cnt;

	// Port A has top priority, so one row lands every cycle
	assign ctrl_we   = (state == game_pkg::LOAD_START) || (state == game_pkg::CLEAR_FIELD);
	assign ctrl_addr = row_cnt;
	assign ctrl_data = (state == game_pkg::LOAD_START) ? game_pkg::START_SCREEN[row_cnt] : '0;
	assign playing   = (state == game_pkg::PLAY);

	// ========================================================================
	// State register and row counter
	// ========================================================================
	always_ff @(posedge clock_50) begin
		if (rst) begin
			state   <= game_pkg::LOAD_START;
			row_cnt <= '0;
		end else begin
			case (state)
				game_pkg::LOAD_START,
				game_pkg::CLEAR_FIELD: begin
					row_cnt <= row_cnt + 1'b1;
					if (row_cnt == game_pkg::row_addr_t'(game_pkg::ROWS - 1)) begin
						if (state == game_pkg::LOAD_START) begin
							state <= game_pkg::WAIT_START;
						end else begin
							state <= game_pkg::PLAY;
						end
					end
				end
				game_pkg::WAIT_START: begin
					if (start_press) begin
						state   <= game_pkg::CLEAR_FIELD;
						row_cnt <= '0;
					end
				end
				game_pkg::PLAY: begin
					// Start during play goes back to the start picture
					if (start_press) begin
						state   <= game_pkg::LOAD_START;
						row_cnt <= '0;
					end
				end
				default: begin
					state <= game_pkg::LOAD_START;
				end
			endcase
		end
	end

	// Store is only written while loading or clearing
	a_no_write_idle: assert property (@(posedge clock_50) disable iff (rst)
		(state == game_pkg::WAIT_START || playing) |-> !ctrl_we);

endmodule

`default_nettype wire

// File: design/player_mover.sv
// Keeps the player column, clamps moves at the edges and requests the player row write
`timescale 1ns/1ps
`default_nettype none

module player_mover (
	input  wire                  clock_50,
	input  wire                  rst,
	input  wire                  playing,
	input  wire                  left_press,
	input  wire                  right_press,
	input  wire                  plr_grant,
	output logic                 plr_we,
	output game_pkg::row_addr_t  plr_addr,
	output game_pkg::row_t       plr_data
);

	logic              playing_q;
	logic              pend;
	logic              start_play;
	logic              move_left;
	logic              move_right;
	game_pkg::col_t    col;
	game_pkg::col_t    col_next;

	assign start_play = playing && !playing_q;

	// Both buttons in one cycle cancel out
	assign move_left  = playing && left_press && !right_press && (col != '0);
	assign move_right = playing && right_press && !left_press &&
		(col != game_pkg::col_t'(game_pkg::COLS - 1));

	always_comb begin
		col_next = col;
		if (start_play) begin
			col_next = game_pkg::PLAYER_START_COL;
		end else if (move_left) begin
			col_next = col - 1'b1;
		end else if (move_right) begin
			col_next = col + 1'b1;
		end
	end

	// A waiting request always carries the newest column
	assign plr_we   = playing && (pend || start_play || move_left || move_right);
	assign plr_addr = game_pkg::PLAYER_ROW;
	assign plr_data = game_pkg::row_t'(1) << col_next;

	always_ff @(posedge clock_50) begin
		if (rst) begin
			playing_q <= 1'b0;
			pend      <= 1'b0;
			col       <= game_pkg::PLAYER_START_COL;
		end else begin
			playing_q <= playing;
			col       <= col_next;
			pend      <= plr_we && !plr_grant;
		end
	end

	a_one_hot: assert property (@(posedge clock_50) disable iff (rst)
		plr_we |-> $onehot(plr_data));

endmodule

`default_nettype wire

// File: design/frame_store.sv
// Eight-row frame memory with a fixed-priority two-writer arbiter and a combinational read port
`timescale 1ns/1ps
`default_nettype none

module frame_store (
	input  wire                  clock_50,
	input  wire                  rst,
	input  wire                  ctrl_we,
	input  game_pkg::row_addr_t  ctrl_addr,
	input  game_pkg::row_t       ctrl_data,
	input  wire                  plr_we,
	input  game_pkg::row_addr_t  plr_addr,
	input  game_pkg::row_t       plr_data,
	input  game_pkg::row_addr_t  rd_addr,
	output logic                 plr_grant,
	output game_pkg::row_t       rd_data
);

	game_pkg::row_t rows [game_pkg::ROWS];

	// ========================================================================
	// Arbiter, controller port always wins
	// ========================================================================
	assign plr_grant = plr_we && !ctrl_we;

	always_ff @(posedge clock_50) begin
		if (rst) begin
			rows <= '{default: '0};
		end else if (ctrl_we) begin
			rows[ctrl_addr] <= ctrl_data;
		end else if (plr_grant) begin
			rows[plr_addr] <= plr_data;
		end
	end

	// Display side
	assign rd_data = rows[rd_addr];

	// Controller writes only outside play and the player only inside it,
	// so the two requests never collide
	a_no_collision: assert property (@(posedge clock_50) disable iff (rst)
		!(ctrl_we && plr_we));

endmodule

`default_nettype wire

// File: design/max7219_driver.sv
// Sends the MAX7219 setup words once and then refreshes all eight digit rows forever
`timescale 1ns/1ps
`default_nettype none

module max7219_driver (
	input  wire                  clock_50,
	input  wire                  rst,
	input  game_pkg::row_t       rd_data,
	output game_pkg::row_addr_t  rd_addr,
	output logic                 max7219_din,
	output logic                 max7219_ncs,
	output logic                 max7219_clk
);

	game_pkg::drv_state_t                       state;
	logic [2:0]                                 setup_idx;
	game_pkg::row_addr_t                        digit;
	logic [game_pkg::FRAME_BITS-1:0]            shreg;
	logic [game_pkg::FRAME_BITS-1:0]            setup_word;
	logic [$clog2(2*game_pkg::SCLK_HALF)-1:0]   div;
	logic [$clog2(game_pkg::FRAME_BITS)-1:0]    bit_cnt;

	// Setup sequence, address byte first
	always_comb begin
		case (setup_idx)
			3'd0:    setup_word = {game_pkg::REG_SHUTDOWN, 8'h00};
			3'd1:    setup_word = {game_pkg::REG_TEST, 8'h00};
			3'd2:    setup_word = {game_pkg::REG_DECODE, 8'h00};
			3'd3:    setup_word = {game_pkg::REG_SCAN_LIMIT, 8'h07};
			3'd4:    setup_word = {game_pkg::REG_INTENSITY, game_pkg::INTENSITY};
			default: setup_word = {game_pkg::REG_SHUTDOWN, 8'h01};
		endcase
	end

	assign rd_addr     = digit;
	assign max7219_din = shreg[game_pkg::FRAME_BITS-1];

	// ========================================================================
	// Word sequencer: load 1 clock, shift 64, gap 1
	// ========================================================================
	always_ff @(posedge clock_50) begin
		if (rst) begin
			state       <= game_pkg::SETUP;
			setup_idx   <= '0;
			digit       <= '0;
			shreg       <= '0;
			div         <= '0;
			bit_cnt     <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
		end else begin
			case (state)
				game_pkg::SETUP: begin
					shreg       <= setup_word;
					setup_idx   <= setup_idx + 1'b1;
					div         <= '0;
					bit_cnt     <= '0;
					max7219_ncs <= 1'b0;
					state       <= game_pkg::SHIFT;
				end
				game_pkg::REFRESH: begin
					// Row sampled once, at the start of the word
					shreg       <= {game_pkg::REG_DIGIT0 + 8'(digit), rd_data};
					digit       <= digit + 1'b1;
					div         <= '0;
					bit_cnt     <= '0;
					max7219_ncs <= 1'b0;
					state       <= game_pkg::SHIFT;
				end
				game_pkg::SHIFT: begin
					div <= div + 1'b1;
					if (div == $bits(div)'(game_pkg::SCLK_HALF - 1)) begin
						max7219_clk <= 1'b1;
					end
					// Falling sclk, next bit goes out
					if (div == $bits(div)'(2*game_pkg::SCLK_HALF - 1)) begin
						div         <= '0;
						max7219_clk <= 1'b0;
						shreg       <= {shreg[game_pkg::FRAME_BITS-2:0], 1'b0};
						bit_cnt     <= bit_cnt + 1'b1;
						if (bit_cnt == $bits(bit_cnt)'(game_pkg::FRAME_BITS - 1)) begin
							max7219_ncs <= 1'b1;
							state       <= game_pkg::GAP;
						end
					end
				end
				game_pkg::GAP: begin
					if (setup_idx == 3'(game_pkg::SETUP_WORDS)) begin
						state <= game_pkg::REFRESH;
					end else begin
						state <= game_pkg::SETUP;
					end
				end
				default: begin
					state <= game_pkg::SETUP;
				end
			endcase
		end
	end

	a_clk_idle: assert property (@(posedge clock_50) disable iff (rst)
		max7219_ncs |-> !max7219_clk);

endmodule

`default_nettype wire

// File: design/game_top.sv
// Game core top level joining the button debouncers, game logic, frame store and MAX7219 link
`timescale 1ns/1ps
`default_nettype none

module game_top (
	input  wire  clock_50,
	input  wire  rst,
	input  wire  start_button_n,
	input  wire  left_button_n,
	input  wire  right_button_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	logic                 start_press;
	logic                 left_press;
	logic                 right_press;
	logic                 playing;
	logic                 ctrl_we;
	game_pkg::row_addr_t  ctrl_addr;
	game_pkg::row_t       ctrl_data;
	logic                 plr_we;
	logic                 plr_grant;
	game_pkg::row_addr_t  plr_addr;
	game_pkg::row_t       plr_data;
	game_pkg::row_addr_t  rd_addr;
	game_pkg::row_t       rd_data;

	// ========================================================================
	// Buttons
	// ========================================================================
	button_debounce u_start_db (
		.clock_50 (clock_50),
		.rst      (rst),
		.button_n (start_button_n),
		.press    (start_press)
	);

	button_debounce u_left_db (
		.clock_50 (clock_50),
		.rst      (rst),
		.button_n (left_button_n),
		.press    (left_press)
	);

	button_debounce u_right_db (
		.clock_50 (clock_50),
		.rst      (rst),
		.button_n (right_button_n),
		.press    (right_press)
	);

	// ========================================================================
	// Game logic and frame memory
	// ========================================================================
	game_control u_ctrl (
		.clock_50    (clock_50),
		.rst         (rst),
		.start_press (start_press),
		.playing     (playing),
		.ctrl_we     (ctrl_we),
		.ctrl_addr   (ctrl_addr),
		.ctrl_data   (ctrl_data)
	);

	player_mover u_player (
		.clock_50    (clock_50),
		.rst         (rst),
		.playing     (playing),
		.left_press  (left_press),
		.right_press (right_press),
		.plr_grant   (plr_grant),
		.plr_we      (plr_we),
		.plr_addr    (plr_addr),
		.plr_data    (plr_data)
	);

	frame_store u_store (
		.clock_50  (clock_50),
		.rst       (rst),
		.ctrl_we   (ctrl_we),
		.ctrl_addr (ctrl_addr),
		.ctrl_data (ctrl_data),
		.plr_we    (plr_we),
		.plr_addr  (plr_addr),
		.plr_data  (plr_data),
		.rd_addr   (rd_addr),
		.plr_grant (plr_grant),
		.rd_data   (rd_data)
	);

	// Display link
	max7219_driver u_driver (
		.clock_50    (clock_50),
		.rst         (rst),
		.rd_data     (rd_data),
		.rd_addr     (rd_addr),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

`default_nettype wire

// File: sim/tb_game.sv
// Self-checking testbench for game_top that decodes the MAX7219 words and compares them with a model
`timescale 1ns/1ps
`default_nettype none

module tb_game;

	// ========================================================================
	// Run length
	// ========================================================================
	localparam int WORD_CYCLES  = 66;
	localparam int SWEEP_CYCLES = 8 * WORD_CYCLES;
	localparam int MAX_HOLD     = game_pkg::DEBOUNCE_CYCLES + 20;
	localparam int MAX_GAP      = 12 + 15;
	localparam int N_ACTIONS    = 100;
	localparam int SETUP_CYCLES = 5 + 6 * WORD_CYCLES + 2 * SWEEP_CYCLES;
	// Hold, gap and up to three sweeps per action
	localparam int CYCLE_LIMIT  = N_ACTIONS * (MAX_HOLD + MAX_GAP + 3 * SWEEP_CYCLES) +
		SETUP_CYCLES;

	localparam int BTN_START = 0;
	localparam int BTN_LEFT  = 1;
	localparam int BTN_RIGHT = 2;

	logic clock_50;
	logic rst;
	logic start_button_n;
	logic left_button_n;
	logic right_button_n;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;

	// Decoder state
	logic [15:0] word_q [$];
	logic [15:0] shift_in;
	int          nbits;
	logic        ncs_q;
	logic        sclk_q;

	// Model state and random source
	logic        mode_play;
	int          col;
	logic [15:0] lfsr_state;
	int          cycles = 0;

	game_top dut_i (
		.clock_50       (clock_50),
		.rst            (rst),
		.start_button_n (start_button_n),
		.left_button_n  (left_button_n),
		.right_button_n (right_button_n),
		.max7219_din    (max7219_din),
		.max7219_ncs    (max7219_ncs),
		.max7219_clk    (max7219_clk)
	);

	initial begin
		clock_50 = 1'b0;
		forever #20 clock_50 = ~clock_50;
	end

	always @(posedge clock_50) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: no result after %0d clock cycles", cycles);
			$display("TEST FAILED");
			$fatal(1, "Simulation ran out of time");
		end
	end

	// ========================================================================
	// Checks and random numbers
	// ========================================================================
	task automatic check(input string name, input int got_val, input int exp_val);
		if (got_val != exp_val) begin
			$display("Fail at %0t ns: %s got 0x%0h expected 0x%0h",
				$time, name, got_val, exp_val);
			$display("TEST FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	// ========================================================================
	// Serial word decoder sampling the link pins at every system clock
	// ========================================================================
	always @(posedge clock_50) begin
		if (rst) begin
			ncs_q    = 1'b1;
			sclk_q   = 1'b0;
			nbits    = 0;
			shift_in = '0;
		end else begin
			if (!max7219_ncs && max7219_clk && !sclk_q) begin
				shift_in = {shift_in[14:0], max7219_din};
				nbits++;
			end
			if (max7219_ncs && !ncs_q) begin
				check("bit_count", nbits, 16);
				word_q.push_back(shift_in);
				nbits = 0;
			end
			ncs_q  = max7219_ncs;
			sclk_q = max7219_clk;
		end
	end

	// ========================================================================
	// Expected display contents
	// ========================================================================
	function automatic logic [15:0] setup_expected(input int i);
		case (i)
			0:       return 16'h0C00;
			1:       return 16'h0F00;
			2:       return 16'h0900;
			3:       return 16'h0B07;
			4:       return 16'h0A0A;
			default: return 16'h0C01;
		endcase
	endfunction

	function automatic logic [7:0] start_row(input int r);
		case (r)
			1, 6:    return 8'h66;
			2, 3:    return 8'h22;
			4, 5:    return 8'h44;
			default: return 8'h00;
		endcase
	endfunction

	function automatic logic [7:0] expected_row(input int r);
		if (!mode_play) begin
			return start_row(r);
		end else if (r == 0) begin
			return 8'(1 << col);
		end else begin
			return 8'h00;
		end
	endfunction

	// A low of DEBOUNCE_CYCLES clocks or more counts as one press
	task automatic update_model(input int which, input int hold);
		if (hold >= game_pkg::DEBOUNCE_CYCLES) begin
			if (which == BTN_START) begin
				mode_play = !mode_play;
				col = 3;
			end else if (mode_play && which == BTN_LEFT && col > 0) begin
				col--;
			end else if (mode_play && which == BTN_RIGHT && col < 7) begin
				col++;
			end
		end
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================
	task automatic get_word(output logic [15:0] w);
		while (word_q.size() == 0) begin
			@(posedge clock_50);
			#2;
		end
		w = word_q.pop_front();
	endtask

	task automatic set_button(input int which, input logic level);
		case (which)
			BTN_START: start_button_n = level;
			BTN_LEFT:  left_button_n  = level;
			default:   right_button_n = level;
		endcase
	endtask

	// Starts and ends 2 ns after a rising edge
	task automatic push_button(input int which, input int hold, input int gap);
		set_button(which, 1'b0);
		repeat (hold) @(posedge clock_50);
		#2;
		set_button(which, 1'b1);
		repeat (gap) @(posedge clock_50);
		#2;
	endtask

	// Words already on the way may hold old rows, so resync on digit 0
	task automatic check_frame();
		logic [15:0] w;
		word_q.delete();
		get_word(w);
		get_word(w);
		while (w[15:8] != 8'h01) begin
			get_word(w);
		end
		for (int r = 0; r < 8; r++) begin
			if (r != 0) begin
				get_word(w);
				check("digit_addr", int'(w[15:8]), r + 1);
			end
			check($sformatf("row%0d", r), int'(w[7:0]), int'(expected_row(r)));
		end
	endtask

	task automatic do_action(input int which, input int hold);
		int gap;
		gap = 12 + rand_bits(4);
		push_button(which, hold, gap);
		update_model(which, hold);
		check_frame();
	endtask

	task automatic random_move();
		int which;
		int hold;
		which = rand_bits(1) ? BTN_RIGHT : BTN_LEFT;
		hold  = game_pkg::DEBOUNCE_CYCLES + 4 + rand_bits(4);
		do_action(which, hold);
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial begin
		logic [15:0] w;
		int          hold;

		rst            = 1'b1;
		start_button_n = 1'b1;
		left_button_n  = 1'b1;
		right_button_n = 1'b1;
		lfsr_state     = 16'd81;
		mode_play      = 1'b0;
		col            = 3;

		repeat (5) @(posedge clock_50);
		#2;
		rst = 1'b0;

		// Six setup words and the addresses of the first sweep
		for (int i = 0; i < 6; i++) begin
			get_word(w);
			check("setup_word", int'(w), int'(setup_expected(i)));
		end
		for (int r = 0; r < 8; r++) begin
			get_word(w);
			check("digit_addr", int'(w[15:8]), r + 1);
		end
		check_frame();

		// Moves before play are ignored
		for (int i = 0; i < 4; i++) begin
			random_move();
		end

		do_action(BTN_START, game_pkg::DEBOUNCE_CYCLES + 6);

		// Short lows on every button including start
		for (int i = 0; i < 6; i++) begin
			hold = 1 + (rand_bits(3) % (game_pkg::DEBOUNCE_CYCLES - 1));
			do_action(rand_bits(2) % 3, hold);
		end

		// Walk into both walls and keep pushing
		for (int i = 0; i < 5; i++) begin
			do_action(BTN_LEFT, game_pkg::DEBOUNCE_CYCLES + 5);
		end
		for (int i = 0; i < 9; i++) begin
			do_action(BTN_RIGHT, game_pkg::DEBOUNCE_CYCLES + 5);
		end

		for (int i = 0; i < 64; i++) begin
			random_move();
		end

		// Back to the start picture and into play again
		do_action(BTN_START, game_pkg::DEBOUNCE_CYCLES + 7);
		random_move();
		random_move();
		do_action(BTN_START, game_pkg::DEBOUNCE_CYCLES + 8);
		do_action(BTN_RIGHT, game_pkg::DEBOUNCE_CYCLES + 4);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
design/game_pkg.sv
design/button_debounce.sv
design/game_control.sv
design/player_mover.sv
design/frame_store.sv
design/max7219_driver.sv
design/game_top.sv
sim/tb_game.sv

// File: Makefile
# Verilator build and run for the LED matrix game core

VERILATOR ?= verilator
TOP       ?= tb_game
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard design/*.sv sim/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f list.f

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
